// File: dcache_pkg.sv
// Geometry is fixed at 4 ways x 16 sets x 16-byte lines, so addresses are 32-bit byte addresses
`default_nettype none

package dcache_pkg;

	// Cache geometry
	localparam int WAYS = 4;
	localparam int SETS = 16;
	localparam int LINE_BYTES = 16;
	localparam int LINE_WORDS = 4;
	localparam int INDEX_W = 4;
	localparam int OFFSET_W = 4;
	localparam int TAG_W = 24;
	localparam int WAY_W = 2;
	localparam int AGE_W = 8;		// Aging tick when the timer is all ones

	// LRU status codes
	localparam logic [1:0] LRU_NEWEST = 2'd3;
	localparam logic [1:0] LRU_INVALID = 2'd0;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [INDEX_W-1:0] index;
		logic [OFFSET_W-1:0] offset;
	} addr_t;

	typedef struct packed {
		logic [1:0] status;			// 0 invalid up to 3 most recent
		logic [TAG_W-1:0] tag;
	} tag_entry_t;

	// Write side works on bytes, read side on words
	typedef union packed {
		logic [LINE_WORDS-1:0][31:0] words;
		logic [LINE_BYTES-1:0][7:0] bytes;
	} line_u;

	typedef enum logic [1:0] {
		BYTE = 2'd0,
		HALF = 2'd1,
		WORD = 2'd2,
		NONE = 2'd3
	} up_order_t;

	// Granted write to the data RAMs and tags
	typedef struct packed {
		logic [WAYS-1:0] way_en;		// One hot or zero
		logic [INDEX_W-1:0] index;
		logic [LINE_BYTES-1:0] byte_en;
		line_u data;
		logic is_upload;
	} wr_cmd_t;

endpackage

`default_nettype wire

// File: dcache_read_port.sv
// Data comes from the RAMs at the buffered index, so writes during a stall show in the held result
`timescale 1ns/100ps
`default_nettype none

module dcache_read_port (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic rd_req,
	input dcache_pkg::addr_t rd_addr,
	input logic rd_stall,
	input logic rd_busy,
	input logic rd_hit_now,
	input logic [dcache_pkg::WAY_W-1:0] rd_hit_way,
	input dcache_pkg::line_u lines [dcache_pkg::WAYS],
	output logic [dcache_pkg::INDEX_W-1:0] rd_index,
	output logic rd_valid,
	output logic rd_hit,
	output logic [31:0] rd_data
);

	logic b_valid;
	logic b_hit;
	logic [dcache_pkg::WAY_W-1:0] b_way;
	logic [1:0] b_word;
	logic [dcache_pkg::INDEX_W-1:0] b_index;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_valid <= 1'b0;
			b_hit <= 1'b0;
		end else if (flush) begin
			b_valid <= 1'b0;
			b_hit <= 1'b0;
		end else if (!rd_stall) begin
			b_valid <= rd_req && !rd_busy;		// Refused requests are re-presented
			b_hit <= rd_hit_now;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (!rd_stall) begin
			b_way <= rd_hit_way;
			b_word <= rd_addr.offset[3:2];
			b_index <= rd_addr.index;
		end
	end

	assign rd_index = b_index;
	assign rd_valid = b_valid && !rd_stall;
	assign rd_hit = rd_valid && b_hit;
	assign rd_data = rd_hit ? lines[b_way].words[b_word] : 32'h0;

endmodule

`default_nettype wire

// File: dcache_tag_store.sv
// Tags live in flops and are searched combinationally; aging only moves while rd_stall is low
`timescale 1ns/100ps
`default_nettype none

module dcache_tag_store (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic rd_req,
	input dcache_pkg::addr_t rd_addr,
	input logic rd_stall,
	output logic rd_busy,
	output logic [dcache_pkg::WAY_W-1:0] rd_hit_way,
	output logic rd_hit_now,
	input dcache_pkg::addr_t up_addr,
	output logic up_hit,
	output logic [dcache_pkg::WAY_W-1:0] up_way,
	input dcache_pkg::addr_t wr_addr,
	output logic [dcache_pkg::WAY_W-1:0] victim_way,
	input dcache_pkg::wr_cmd_t wr_cmd
);

	dcache_pkg::tag_entry_t tags [dcache_pkg::WAYS][dcache_pkg::SETS];
	dcache_pkg::tag_entry_t [dcache_pkg::WAYS-1:0] rd_set;
	dcache_pkg::tag_entry_t [dcache_pkg::WAYS-1:0] up_set;
	dcache_pkg::tag_entry_t [dcache_pkg::WAYS-1:0] wr_set;
	logic [dcache_pkg::AGE_W-1:0] age_timer;
	logic age_tick;
	logic fill_now;

	// Lowest valid way with a matching tag
	function automatic logic [dcache_pkg::WAY_W:0] hit_check(
		input logic [dcache_pkg::TAG_W-1:0] tag,
		input dcache_pkg::tag_entry_t [dcache_pkg::WAYS-1:0] set_e
	);
		logic [dcache_pkg::WAY_W:0] res;
		res = '0;
		for (int w = dcache_pkg::WAYS - 1; w >= 0; w--) begin
			if (set_e[w].status != dcache_pkg::LRU_INVALID && set_e[w].tag == tag) begin
				res = {1'b1, w[dcache_pkg::WAY_W-1:0]};
			end
		end
		return res;
	endfunction

	// Matching line first, then invalid, status 1, status 2, else the last way
	function automatic logic [dcache_pkg::WAY_W-1:0] victim_search(
		input logic [dcache_pkg::TAG_W-1:0] tag,
		input dcache_pkg::tag_entry_t [dcache_pkg::WAYS-1:0] set_e
	);
		logic [dcache_pkg::WAY_W:0] hit;
		logic [dcache_pkg::WAY_W-1:0] way;
		logic found;
		hit = hit_check(tag, set_e);
		found = hit[dcache_pkg::WAY_W];
		way = found ? hit[dcache_pkg::WAY_W-1:0] : '1;
		for (int s = 0; s < 3; s++) begin
			for (int w = 0; w < dcache_pkg::WAYS; w++) begin
				if (!found && set_e[w].status == s[1:0]) begin
					way = w[dcache_pkg::WAY_W-1:0];
					found = 1'b1;
				end
			end
		end
		return way;
	endfunction

	always_comb begin
		for (int w = 0; w < dcache_pkg::WAYS; w++) begin
			rd_set[w] = tags[w][rd_addr.index];
			up_set[w] = tags[w][up_addr.index];
			wr_set[w] = tags[w][wr_addr.index];
		end
	end

	assign {rd_hit_now, rd_hit_way} = hit_check(rd_addr.tag, rd_set);
	assign {up_hit, up_way} = hit_check(up_addr.tag, up_set);
	assign victim_way = victim_search(wr_addr.tag, wr_set);

	// A fill into the read set would change the hit under the request
	assign fill_now = |wr_cmd.way_en && !wr_cmd.is_upload;
	assign rd_busy = rd_stall || (rd_req && fill_now && wr_cmd.index == rd_addr.index);

	assign age_tick = (age_timer == '1) && !rd_stall;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			age_timer <= '0;
		end else if (flush) begin
			age_timer <= '0;
		end else if (!rd_stall) begin
			age_timer <= age_timer + 1'b1;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int w = 0; w < dcache_pkg::WAYS; w++) begin
				for (int s = 0; s < dcache_pkg::SETS; s++) begin
					tags[w][s].status <= dcache_pkg::LRU_INVALID;
				end
			end
		end else if (flush) begin
			for (int w = 0; w < dcache_pkg::WAYS; w++) begin
				for (int s = 0; s < dcache_pkg::SETS; s++) begin
					tags[w][s].status <= dcache_pkg::LRU_INVALID;
				end
			end
		end else if (|wr_cmd.way_en) begin
			for (int w = 0; w < dcache_pkg::WAYS; w++) begin
				if (wr_cmd.way_en[w] && wr_cmd.is_upload) begin
					if (tags[w][wr_cmd.index].status != dcache_pkg::LRU_NEWEST) begin
						tags[w][wr_cmd.index].status <= tags[w][wr_cmd.index].status + 2'd1;
					end
				end else if (wr_cmd.way_en[w]) begin
					tags[w][wr_cmd.index].status <= dcache_pkg::LRU_NEWEST;
					tags[w][wr_cmd.index].tag <= wr_addr.tag;
				end
			end
		end else begin
			if (age_tick) begin
				for (int w = 0; w < dcache_pkg::WAYS; w++) begin
					for (int s = 0; s < dcache_pkg::SETS; s++) begin
						if (tags[w][s].status > 2'd1) begin
							tags[w][s].status <= tags[w][s].status - 2'd1;
						end
					end
				end
			end
			// Read refresh overrides the aging of its own entry
			if (rd_req && !rd_busy && rd_hit_now) begin
				tags[rd_hit_way][rd_addr.index].status <= dcache_pkg::LRU_NEWEST;
			end
		end
	end

	// Each tag write is the upload's hit way or the fill's victim, never a mix
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(|wr_cmd.way_en) |-> (wr_cmd.is_upload
			? (up_hit && wr_cmd.way_en == (dcache_pkg::WAYS'(1) << up_way))
			: (wr_cmd.way_en == (dcache_pkg::WAYS'(1) << victim_way))));

endmodule

`default_nettype wire

// File: dcache_top.sv
// Write-through data cache; uploads to absent lines are dropped and fills wait on uploads
`timescale 1ns/100ps
`default_nettype none

module dcache_top (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic rd_req,
	input dcache_pkg::addr_t rd_addr,
	input logic rd_stall,
	output logic rd_busy,
	output logic rd_valid,
	output logic rd_hit,
	output logic [31:0] rd_data,
	input logic wr_req,
	input dcache_pkg::addr_t wr_addr,
	input dcache_pkg::line_u wr_line,
	output logic wr_busy,
	input logic up_req,
	input dcache_pkg::addr_t up_addr,
	input dcache_pkg::up_order_t up_order,
	input logic [31:0] up_data
);

	dcache_pkg::wr_cmd_t wr_cmd;
	dcache_pkg::line_u way_lines [dcache_pkg::WAYS];
	logic [dcache_pkg::WAY_W-1:0] rd_hit_way;
	logic [dcache_pkg::WAY_W-1:0] up_way;
	logic [dcache_pkg::WAY_W-1:0] victim_way;
	logic [dcache_pkg::INDEX_W-1:0] rd_index;
	logic rd_hit_now;
	logic up_hit;

	dcache_tag_store u_tags (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .flush(flush),
		.rd_req(rd_req), .rd_addr(rd_addr), .rd_stall(rd_stall), .rd_busy(rd_busy),
		.rd_hit_way(rd_hit_way), .rd_hit_now(rd_hit_now),
		.up_addr(up_addr), .up_hit(up_hit), .up_way(up_way),
		.wr_addr(wr_addr), .victim_way(victim_way), .wr_cmd(wr_cmd)
	);

	dcache_write_arbiter u_arb (
		.up_req(up_req), .up_addr(up_addr), .up_order(up_order), .up_data(up_data),
		.up_hit(up_hit), .up_way(up_way),
		.wr_req(wr_req), .wr_addr(wr_addr), .wr_line(wr_line), .victim_way(victim_way),
		.wr_busy(wr_busy), .wr_cmd(wr_cmd)
	);

	for (genvar g = 0; g < dcache_pkg::WAYS; g++) begin : g_way
		dcache_way_ram #(.WAY_ID(g)) u_ram (
			.iCLOCK(iCLOCK),
			.wr_cmd(wr_cmd),
			.rd_index(rd_index),
			.rd_line(way_lines[g])
		);
	end

	dcache_read_port u_rd (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .flush(flush),
		.rd_req(rd_req), .rd_addr(rd_addr), .rd_stall(rd_stall), .rd_busy(rd_busy),
		.rd_hit_now(rd_hit_now), .rd_hit_way(rd_hit_way),
		.lines(way_lines), .rd_index(rd_index),
		.rd_valid(rd_valid), .rd_hit(rd_hit), .rd_data(rd_data)
	);

endmodule

`default_nettype wire

// File: dcache_way_ram.sv
// One way of line storage without reset; contents are undefined until a fill writes them
`timescale 1ns/100ps
`default_nettype none

module dcache_way_ram #(
	parameter int WAY_ID = 0
) (
	input logic iCLOCK,
	input dcache_pkg::wr_cmd_t wr_cmd,
	input logic [dcache_pkg::INDEX_W-1:0] rd_index,
	output dcache_pkg::line_u rd_line
);

	dcache_pkg::line_u mem [dcache_pkg::SETS];

	always_ff @(posedge iCLOCK) begin
		if (wr_cmd.way_en[WAY_ID]) begin
			for (int b = 0; b < dcache_pkg::LINE_BYTES; b++) begin
				if (wr_cmd.byte_en[b]) begin
					mem[wr_cmd.index].bytes[b] <= wr_cmd.data.bytes[b];
				end
			end
		end
	end

	assign rd_line = mem[rd_index];		// Asynchronous read

endmodule

`default_nettype wire

// File: dcache_write_arbiter.sv
// Uploads always take the write port, so a fill stalls whenever up_req is high
`timescale 1ns/100ps
`default_nettype none

module dcache_write_arbiter (
	input logic up_req,
	input dcache_pkg::addr_t up_addr,
	input dcache_pkg::up_order_t up_order,
	input logic [31:0] up_data,
	input logic up_hit,
	input logic [dcache_pkg::WAY_W-1:0] up_way,
	input logic wr_req,
	input dcache_pkg::addr_t wr_addr,
	input dcache_pkg::line_u wr_line,
	input logic [dcache_pkg::WAY_W-1:0] victim_way,
	output logic wr_busy,
	output dcache_pkg::wr_cmd_t wr_cmd
);

	logic [dcache_pkg::LINE_BYTES-1:0] up_byte_en;

	// Aligned lanes at the offset
	always_comb begin
		case (up_order)
			dcache_pkg::BYTE: up_byte_en = 16'h0001 << up_addr.offset;
			dcache_pkg::HALF: up_byte_en = 16'h0003 << {up_addr.offset[3:1], 1'b0};
			dcache_pkg::WORD: up_byte_en = 16'h000f << {up_addr.offset[3:2], 2'b00};
			default: up_byte_en = '0;
		endcase
	end

	always_comb begin
		wr_cmd = '0;
		wr_cmd.is_upload = up_req;
		if (up_req) begin
			wr_cmd.index = up_addr.index;
			wr_cmd.byte_en = up_byte_en;
			wr_cmd.data.words = {dcache_pkg::LINE_WORDS{up_data}};	// Same word in every slot
			if (up_hit && up_order != dcache_pkg::NONE) begin
				wr_cmd.way_en = dcache_pkg::WAYS'(1) << up_way;
			end
			// Misses are dropped, memory below holds the data
		end else if (wr_req) begin
			wr_cmd.index = wr_addr.index;
			wr_cmd.byte_en = '1;
			wr_cmd.data = wr_line;
			wr_cmd.way_en = dcache_pkg::WAYS'(1) << victim_way;
		end
	end

	assign wr_busy = up_req;

	// A granted way always gets at least one byte
	always_comb begin
		assert ($onehot0(wr_cmd.way_en) && (wr_cmd.way_en == '0 || wr_cmd.byte_en != '0))
			else $error("write port enables a bad way or byte set");
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds and runs tb_dcache with Verilator, exits non-zero on any failure
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_dcache -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_dcache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Something failed" "$LOG"; then
	exit 1
fi
exit 0

// File: tb_dcache_table.svh
// Included inside tb_dcache after op_t is declared, so it cannot be compiled on its own
`ifndef TB_DCACHE_TABLE_SVH
`define TB_DCACHE_TABLE_SVH

// Each row holds kind, byte address, upload size, upload data, stall and expected hit
// Expected hit means line present for an upload, and stall means rd_stall held for a fill
localparam int N_OPS = 36;
localparam op_t OPS [N_OPS] = '{
	'{OP_READ,   32'h0000_0000, dcache_pkg::NONE, 32'h0000_0000, 4'd0, 1'b0},	// Empty cache
	'{OP_READ,   32'h1234_5678, dcache_pkg::NONE, 32'h0000_0000, 4'd0, 1'b0},
	'{OP_FILL,   32'h0000_1230, dcache_pkg::NONE, 32'h0000_0000, 4'd0, 1'b0},
	'{OP_READ,   32'h0000_1230, dcache_pkg::NONE, 32'h0000_0000, 4'd0, 1'b1},
	'{OP_READ,   32'h0000_1234, dcache_pkg::NONE, 32'h0000_0000, 4'd0, 1'b1},
	'{OP_READ,   32'h0000_1238, dcache_pkg::NONE, 32'h0000_0000, 4'd0, 1'b1},
	'{OP_READ,   32'h0000_123c, dcache_pkg::NONE, 32'h0000_0000, 4'd0, 1'b1},
	// Store-through into the filled line, then one to an absent tag of the same set
	'{OP_UPLOAD, 32'h0000_1231, dcache_pkg::BYTE, 32'haabb_ccdd, 4'd0, 1'b1},
	'{OP_UPLOAD, 32'h0000_1236, dcache_pkg::HALF, 32'h1122_3344, 4'd0, 1'b1},
	'{OP_UPLOAD, 32'h0000_123a, dcache_pkg::WORD, 32'hdead_beef, 4'd0, 1'b1},
	'{OP_UPLOAD, 32'h0000_5630, dcache_pkg::WORD, 32'hcafe_f00d, 4'd0, 1'b0},
	'{OP_READ,   32'h0000_1230, dcache_pkg::NONE, 32'h0000_0000, 4'd0, 1'b1},
	'{OP_READ,   32'h0000_1234, dcache_pkg::NONE, 32'h0000_0000, 4'd0, 1'b1},
	'{OP_READ,   32'h0000_1238, dcache_pkg::NONE, 32'h0000_0000, 4'd0, 1'b1},
	'{OP_READ,   32'h0000_123c, dcache_pkg::NONE, 32'h0000_0000, 4'd0, 1'b1},
	'{OP_READ,   32'h0000_5630, dcache_pkg::NONE, 32'h0000_0000, 4'd0, 1'b0},
	// Five tags into set 9 with aging held off, the fifth lands in way 3
	'{OP_FILL,   32'h0001_0090, dcache_pkg::NONE, 32'h0000_0000, 4'd1, 1'b0},
	'{OP_FILL,   32'h0002_0090, dcache_pkg::NONE, 32'h0000_0000, 4'd1, 1'b0},
	'{OP_FILL,   32'h0003_0090, dcache_pkg::NONE, 32'h0000_0000, 4'd1, 1'b0},
	'{OP_FILL,   32'h0004_0090, dcache_pkg::NONE, 32'h0000_0000, 4'd1, 1'b0},
	'{OP_FILL,   32'h0005_0090, dcache_pkg::NONE, 32'h0000_0000, 4'd1, 1'b0},
	'{OP_READ,   32'h0001_0090, dcache_pkg::NONE, 32'h0000_0000, 4'd0, 1'b1},
	'{OP_READ,   32'h0002_0094, dcache_pkg::NONE, 32'h0000_0000, 4'd0, 1'b1},
	'{OP_READ,   32'h0003_0098, dcache_pkg::NONE, 32'h0000_0000, 4'd0, 1'b1},
	'{OP_READ,   32'h0004_009c, dcache_pkg::NONE, 32'h0000_0000, 4'd0, 1'b0},
	'{OP_READ,   32'h0005_009c, dcache_pkg::NONE, 32'h0000_0000, 4'd0, 1'b1},
	'{OP_READ,   32'h0000_1234, dcache_pkg::NONE, 32'h0000_0000, 4'd3, 1'b1},	// Stalled hit
	'{OP_READ,   32'h0004_009c, dcache_pkg::NONE, 32'h0000_0000, 4'd2, 1'b0},	// Stalled miss
	'{OP_FLUSH,  32'h0000_0000, dcache_pkg::NONE, 32'h0000_0000, 4'd0, 1'b0},
	'{OP_READ,   32'h0000_1230, dcache_pkg::NONE, 32'h0000_0000, 4'd0, 1'b0},
	'{OP_READ,   32'h0001_0090, dcache_pkg::NONE, 32'h0000_0000, 4'd0, 1'b0},
	'{OP_READ,   32'h0002_0094, dcache_pkg::NONE, 32'h0000_0000, 4'd0, 1'b0},
	'{OP_READ,   32'h0003_0098, dcache_pkg::NONE, 32'h0000_0000, 4'd0, 1'b0},
	'{OP_READ,   32'h0005_009c, dcache_pkg::NONE, 32'h0000_0000, 4'd0, 1'b0},
	'{OP_FILL,   32'h0000_1230, dcache_pkg::NONE, 32'h0000_0000, 4'd0, 1'b0},	// Refill after flush
	'{OP_READ,   32'h0000_1238, dcache_pkg::NONE, 32'h0000_0000, 4'd0, 1'b1}
};

`endif

// File: tb_dcache.sv
// Expected words come from a line model, and table rows must not depend on aging timer phase
`timescale 1ns/100ps
`default_nettype none

module tb_dcache;

	localparam int WAIT_LIMIT = 50;		// Cycles before any wait gives up

	typedef enum logic [1:0] {
		OP_READ,
		OP_FILL,
		OP_UPLOAD,
		OP_FLUSH
	} op_kind_t;

	typedef struct packed {
		op_kind_t kind;
		logic [31:0] addr;
		dcache_pkg::up_order_t order;
		logic [31:0] data;
		logic [3:0] stall;
		logic exp_hit;
	} op_t;

	`include "tb_dcache_table.svh"

	logic iCLOCK;
	logic inRESET;
	logic flush;
	logic rd_req;
	dcache_pkg::addr_t rd_addr;
	logic rd_stall;
	logic rd_busy;
	logic rd_valid;
	logic rd_hit;
	logic [31:0] rd_data;
	logic wr_req;
	dcache_pkg::addr_t wr_addr;
	dcache_pkg::line_u wr_line;
	logic wr_busy;
	logic up_req;
	dcache_pkg::addr_t up_addr;
	dcache_pkg::up_order_t up_order;
	logic [31:0] up_data;

	logic [127:0] model [logic [27:0]];		// Line contents by line address
	logic [31:0] lfsr;
	int checks;
	int errors;
	int timeouts;

	dcache_top uut (.*);

	always #20 iCLOCK = ~iCLOCK;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("[FAIL] %0t ns %s got %h expected %h", $time, what, got, want);
		end
	endtask

	task automatic read_word(input op_t op);
		int n;
		int w;
		logic [31:0] want;
		w = int'(op.addr[3:2]);
		want = 32'h0;		// Misses read as zero
		if (op.exp_hit && model.exists(op.addr[31:4])) begin
			want = model[op.addr[31:4]][32*w +: 32];
		end
		@(posedge iCLOCK);
		#2;
		rd_stall = 1'b0;
		rd_addr = op.addr;
		rd_req = 1'b1;
		n = 0;
		@(negedge iCLOCK);
		while (rd_busy && n < WAIT_LIMIT) begin
			@(negedge iCLOCK);
			n++;
		end
		if (rd_busy) begin
			timeouts++;
			$display("Timeout at %0t ns, read of %h was never accepted", $time, op.addr);
			return;
		end
		@(posedge iCLOCK);
		#2;
		rd_req = 1'b0;
		if (op.stall != 0) begin
			rd_stall = 1'b1;
			repeat (op.stall) begin
				@(negedge iCLOCK);
				check_value($sformatf("rd_valid under stall @%h", op.addr), rd_valid, 0);
				@(posedge iCLOCK);
				#2;
			end
			rd_stall = 1'b0;
		end
		n = 0;
		@(negedge iCLOCK);
		while (!rd_valid && n < WAIT_LIMIT) begin
			@(negedge iCLOCK);
			n++;
		end
		if (!rd_valid) begin
			timeouts++;
			$display("Timeout at %0t ns, no read result for %h", $time, op.addr);
			return;
		end
		check_value($sformatf("rd_hit @%h", op.addr), rd_hit, op.exp_hit);
		check_value($sformatf("rd_data @%h", op.addr), rd_data, want);
	endtask

	task automatic fill_line(input op_t op);
		int n;
		logic [127:0] line;
		for (int i = 0; i < 128; i++) begin
			line[i] = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
		@(posedge iCLOCK);
		#2;
		rd_stall = (op.stall != 0);		// Keeps the aging timer still
		wr_addr = op.addr;
		wr_line = line;
		wr_req = 1'b1;
		n = 0;
		@(negedge iCLOCK);
		while (wr_busy && n < WAIT_LIMIT) begin
			@(negedge iCLOCK);
			n++;
		end
		if (wr_busy) begin
			timeouts++;
			$display("Timeout at %0t ns, fill of %h was never accepted", $time, op.addr);
			return;
		end
		@(posedge iCLOCK);
		#2;
		wr_req = 1'b0;
		model[op.addr[31:4]] = line;
	endtask

	task automatic upload_data(input op_t op);
		int first;
		int count;
		logic [127:0] line;
		@(posedge iCLOCK);
		#2;
		rd_stall = 1'b0;
		up_addr = op.addr;
		up_order = op.order;
		up_data = op.data;
		up_req = 1'b1;
		@(negedge iCLOCK);
		check_value($sformatf("wr_busy during upload @%h", op.addr), wr_busy, 1);
		@(posedge iCLOCK);
		#2;
		up_req = 1'b0;
		case (op.order)
			dcache_pkg::BYTE: count = 1;
			dcache_pkg::HALF: count = 2;
			dcache_pkg::WORD: count = 4;
			default: count = 0;
		endcase
		first = int'(op.addr[3:0]) & ~(count - 1);		// Aligned to the access size
		if (op.exp_hit && model.exists(op.addr[31:4])) begin
			line = model[op.addr[31:4]];
			for (int b = first; b < first + count; b++) begin
				line[8*b +: 8] = op.data[8*(b%4) +: 8];		// Byte lane of the data word
			end
			model[op.addr[31:4]] = line;
		end
	endtask

	task automatic flush_cache();
		@(posedge iCLOCK);
		#2;
		rd_stall = 1'b0;
		flush = 1'b1;
		@(posedge iCLOCK);
		#2;
		flush = 1'b0;
		model.delete();
	endtask

	initial begin
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		flush = 1'b0;
		rd_req = 1'b0;
		rd_addr = '0;
		rd_stall = 1'b0;
		wr_req = 1'b0;
		wr_addr = '0;
		wr_line = '0;
		up_req = 1'b0;
		up_addr = '0;
		up_order = dcache_pkg::NONE;
		up_data = 32'h0;
		lfsr = 32'h41a7_135f;
		checks = 0;
		errors = 0;
		timeouts = 0;
		repeat (5) @(posedge iCLOCK);
		#2;
		inRESET = 1'b1;
		@(negedge iCLOCK);
		check_value("rd_valid after reset", rd_valid, 0);
		check_value("rd_hit after reset", rd_hit, 0);
		check_value("rd_busy after reset", rd_busy, 0);
		check_value("wr_busy after reset", wr_busy, 0);
		for (int i = 0; i < N_OPS && timeouts == 0; i++) begin
			case (OPS[i].kind)
				OP_READ: read_word(OPS[i]);
				OP_FILL: fill_line(OPS[i]);
				OP_UPLOAD: upload_data(OPS[i]);
				default: flush_cache();
			endcase
		end
		$display("Checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
dcache_pkg.sv
dcache_tag_store.sv
dcache_way_ram.sv
dcache_write_arbiter.sv
dcache_read_port.sv
dcache_top.sv
tb_dcache.sv
